// File: source/flush_pkg.sv
`default_nettype none

package flush_pkg;

    // Cache geometry
    localparam int unsigned SetWidth = 4;
    localparam int unsigned Ways = 2;
    localparam int unsigned ClOffsetWidth = 4;
    localparam int unsigned NlineWidth = 28;
    localparam int unsigned AccessWidth = 64;
    localparam int unsigned AccessPerLine = 2;
    localparam int unsigned AccIdxWidth = $clog2(AccessPerLine);

    // Memory side
    localparam int unsigned MemDataWidth = 32;
    localparam int unsigned FlitsPerLine = 4;
    localparam int unsigned MemIdWidth = 4;
    localparam int unsigned MemLenWidth = 8;
    localparam int unsigned MemAddrWidth = NlineWidth + ClOffsetWidth;

    typedef logic [NlineWidth-1:0] nline_t;
    typedef logic [SetWidth-1:0] set_t;
    typedef logic [Ways-1:0] way_vec_t;
    typedef logic [AccIdxWidth-1:0] acc_idx_t;
    typedef logic [AccessWidth-1:0] access_data_t;
    typedef logic [MemDataWidth-1:0] mem_data_t;
    typedef logic [MemIdWidth-1:0] mem_id_t;
    typedef logic [MemLenWidth-1:0] mem_len_t;
    typedef logic [MemAddrWidth-1:0] mem_addr_t;

    typedef struct packed {
        set_t         set;
        way_vec_t     way;
        acc_idx_t     acc;
        access_data_t data;
    } fill_req_t;

    typedef struct packed {
        mem_addr_t addr;
        mem_len_t  len;
        mem_id_t   id;
    } mem_wreq_t;

    typedef struct packed {
        mem_data_t data;
        logic      last;
    } mem_wdata_t;

    typedef struct packed {
        mem_id_t id;
    } mem_wresp_t;

    // One access word on its way to the resizer
    typedef struct packed {
        access_data_t data;
        logic         last;
    } acc_word_t;

endpackage

`default_nettype wire

// File: source/flush_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module flush_fifo #(
    parameter int unsigned Depth = 2,
    parameter type payload_t = logic
) (
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire logic     w_i,
    output logic          wok_o,
    input  wire payload_t wdata_i,
    input  wire logic     r_i,
    output logic          rok_o,
    output payload_t      rdata_o
);

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    payload_t            buf_q [Depth];
    logic [PtrWidth-1:0] wptr_q;
    logic [PtrWidth-1:0] rptr_q;
    logic [CntWidth-1:0] cnt_q;
    logic                push;
    logic                pop;

    assign wok_o = (cnt_q != CntWidth'(Depth));
    assign rok_o = (cnt_q != '0);
    assign push = w_i & wok_o;
    assign pop = r_i & rok_o;
    assign rdata_o = buf_q[rptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q <= '0;
            rptr_q <= '0;
            cnt_q <= '0;
        end else begin
            if (push) begin
                wptr_q <= (wptr_q == PtrWidth'(Depth - 1)) ? '0 : wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= (rptr_q == PtrWidth'(Depth - 1)) ? '0 : rptr_q + 1'b1;
            end
            cnt_q <= cnt_q + CntWidth'(push) - CntWidth'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_q[wptr_q] <= wdata_i;
        end
    end

    // Producers and consumers must honour the flags
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni) w_i |-> wok_o)
        else $error("flush_fifo: write while full");
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni) r_i |-> rok_o)
        else $error("flush_fifo: read while empty");

endmodule

`default_nettype wire

// File: source/flush_resize.sv
`timescale 1ns/1ps
`default_nettype none

module flush_resize (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,
    input  wire logic                w_i,
    output logic                     wok_o,
    input  wire flush_pkg::acc_word_t wdata_i,
    input  wire logic                r_i,
    output logic                     rok_o,
    output flush_pkg::mem_data_t     rdata_o
);

    import flush_pkg::*;

    acc_word_t head;
    logic      half_q;
    logic      pop;

    // Word buffer between the array read and the memory flits
    flush_fifo #(
        .Depth     (2),
        .payload_t (acc_word_t)
    ) word_fifo_i (
        .clk_i,
        .rst_ni,
        .w_i,
        .wok_o,
        .wdata_i,
        .r_i     (pop),
        .rok_o,
        .rdata_o (head)
    );

    // Low half goes out first
    assign rdata_o = half_q ? head.data[AccessWidth-1 -: MemDataWidth]
                            : head.data[MemDataWidth-1:0];

    // Head word retires once its upper half is taken
    assign pop = r_i & rok_o & half_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            half_q <= 1'b0;
        end else if (r_i && rok_o) begin
            half_q <= ~half_q;
        end
    end

endmodule

`default_nettype wire

// File: source/flush_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module flush_data_array (
    input  wire logic                 clk_i,
    input  wire logic                 fill_valid_i,
    input  wire flush_pkg::fill_req_t fill_i,
    input  wire logic                 rd_i,
    input  wire flush_pkg::set_t      rd_set_i,
    input  wire flush_pkg::way_vec_t  rd_way_i,
    input  wire flush_pkg::acc_idx_t  rd_acc_i,
    output flush_pkg::access_data_t   rd_data_o
);

    import flush_pkg::*;

    localparam int unsigned NumSets = 1 << SetWidth;

    access_data_t mem_q [NumSets][Ways][AccessPerLine];
    access_data_t rd_word;

    // Fill writes every way selected in the vector
    always_ff @(posedge clk_i) begin
        if (fill_valid_i) begin
            for (int w = 0; w < Ways; w++) begin
                if (fill_i.way[w]) begin
                    mem_q[fill_i.set][w][fill_i.acc] <= fill_i.data;
                end
            end
        end
    end

    // One-hot way mux
    always_comb begin
        rd_word = '0;
        for (int w = 0; w < Ways; w++) begin
            if (rd_way_i[w]) begin
                rd_word = mem_q[rd_set_i][w][rd_acc_i];
            end
        end
    end

    // Output holds its word until the next read
    always_ff @(posedge clk_i) begin
        if (rd_i) begin
            rd_data_o <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: source/flush_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module flush_ctrl #(
    parameter int unsigned FlushEntries = 4
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,

    input  wire logic                    flush_alloc_i,
    input  wire flush_pkg::nline_t       flush_alloc_nline_i,
    input  wire flush_pkg::way_vec_t     flush_alloc_way_i,
    output logic                         flush_alloc_ready_o,
    output logic                         flush_empty_o,
    output logic                         flush_full_o,
    output logic                         flush_busy_o,

    input  wire flush_pkg::nline_t       flush_check_nline_i,
    output logic                         flush_check_hit_o,
    output logic                         flush_ack_o,
    output flush_pkg::nline_t            flush_ack_nline_o,

    output logic                         rd_o,
    output flush_pkg::set_t              rd_set_o,
    output flush_pkg::way_vec_t          rd_way_o,
    output flush_pkg::acc_idx_t          rd_acc_o,
    input  wire flush_pkg::access_data_t rd_data_i,

    output logic                         meta_w_o,
    input  wire logic                    meta_wok_i,
    output flush_pkg::mem_wreq_t         meta_o,

    output logic                         rs_w_o,
    input  wire logic                    rs_wok_i,
    output flush_pkg::acc_word_t         rs_wdata_o,

    input  wire logic                    flit_rok_i,
    input  wire flush_pkg::mem_data_t    flit_i,
    input  wire logic                    mem_wdata_ready_i,
    output logic                         mem_wdata_valid_o,
    output flush_pkg::mem_wdata_t        mem_wdata_o,

    input  wire logic                    mem_wresp_valid_i,
    input  wire flush_pkg::mem_wresp_t   mem_wresp_i,
    output logic                         mem_wresp_ready_o
);

    import flush_pkg::*;

    localparam int unsigned IdxWidth = (FlushEntries > 1) ? $clog2(FlushEntries) : 1;
    localparam int unsigned FlitCntWidth = (FlitsPerLine > 1) ? $clog2(FlitsPerLine) : 1;

    typedef enum logic {
        IDLE,
        SEND
    } state_e;

    state_e                  state_q, state_d;
    acc_idx_t                acc_q, acc_d;
    logic [FlushEntries-1:0] dir_valid_q;
    nline_t                  dir_nline_q [FlushEntries];
    set_t                    set_q;
    way_vec_t                way_q;
    set_t                    alloc_set;
    logic [IdxWidth-1:0]     free_ptr;
    logic [IdxWidth-1:0]     ack_ptr;
    logic [FlushEntries-1:0] alloc_bv;
    logic [FlushEntries-1:0] ack_bv;
    logic [FlushEntries-1:0] check_bv;
    logic                    accept;
    logic                    eol;
    logic [FlitCntWidth-1:0] flit_cnt_q;
    logic                    flit_last;

    assign flush_full_o = &dir_valid_q;
    assign flush_empty_o = ~(|dir_valid_q);
    assign flush_busy_o = (state_q == SEND);
    assign flush_alloc_ready_o = (state_q == IDLE) & ~flush_full_o & meta_wok_i & rs_wok_i;

    assign accept = flush_alloc_i & flush_alloc_ready_o;
    assign alloc_set = flush_alloc_nline_i[SetWidth-1:0];
    assign eol = (acc_q == AccIdxWidth'(AccessPerLine - 1));

    // Lowest free directory slot
    always_comb begin
        free_ptr = '0;
        for (int i = FlushEntries - 1; i >= 0; i--) begin
            if (!dir_valid_q[i]) begin
                free_ptr = IdxWidth'(i);
            end
        end
    end

    // Read sequencer issues the first read in the accepting cycle
    always_comb begin
        state_d = state_q;
        acc_d = acc_q;
        rd_o = 1'b0;
        rd_set_o = set_q;
        rd_way_o = way_q;
        rd_acc_o = acc_q + 1'b1;
        rs_w_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    rd_o = 1'b1;
                    rd_set_o = alloc_set;
                    rd_way_o = flush_alloc_way_i;
                    rd_acc_o = '0;
                    acc_d = '0;
                    state_d = SEND;
                end
            end
            SEND: begin
                rs_w_o = rs_wok_i;
                if (rs_wok_i) begin
                    if (eol) begin
                        state_d = IDLE;
                    end else begin
                        rd_o = 1'b1;
                        acc_d = acc_q + 1'b1;
                    end
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign rs_wdata_o = '{data: rd_data_i, last: eol};

    // Request leaves with the directory slot as its ID
    assign meta_w_o = accept;
    assign meta_o = '{
        addr: {flush_alloc_nline_i, {ClOffsetWidth{1'b0}}},
        len:  mem_len_t'(FlitsPerLine - 1),
        id:   mem_id_t'(free_ptr)
    };

    // Flit counter marks the end of each line
    assign flit_last = (flit_cnt_q == FlitCntWidth'(FlitsPerLine - 1));
    assign mem_wdata_valid_o = flit_rok_i;
    assign mem_wdata_o = '{data: flit_i, last: flit_last};

    assign mem_wresp_ready_o = 1'b1;
    assign ack_ptr = IdxWidth'(mem_wresp_i.id);
    assign flush_ack_o = mem_wresp_valid_i;
    assign flush_ack_nline_o = dir_nline_q[ack_ptr];

    for (genvar i = 0; i < FlushEntries; i++) begin : gen_entry
        assign alloc_bv[i] = accept & (free_ptr == IdxWidth'(i));
        assign ack_bv[i] = mem_wresp_valid_i & (ack_ptr == IdxWidth'(i));
        assign check_bv[i] = (dir_nline_q[i] == flush_check_nline_i);
    end

    // Lines being acknowledged no longer count as pending
    assign flush_check_hit_o = |(dir_valid_q & ~ack_bv & check_bv);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            acc_q <= '0;
            dir_valid_q <= '0;
            flit_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            acc_q <= acc_d;
            dir_valid_q <= (dir_valid_q & ~ack_bv) | alloc_bv;
            if (mem_wdata_valid_o && mem_wdata_ready_i) begin
                flit_cnt_q <= flit_last ? '0 : flit_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dir_nline_q[free_ptr] <= flush_alloc_nline_i;
            set_q <= alloc_set;
            way_q <= flush_alloc_way_i;
        end
    end

    // Memory only answers requests that are still in flight
    a_resp_known_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_wresp_valid_i |-> dir_valid_q[ack_ptr])
        else $error("flush_ctrl: write response for a free directory entry");

endmodule

`default_nettype wire

// File: source/flush_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module flush_subsystem #(
    parameter int unsigned FlushEntries = 4
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,

    input  wire logic                  fill_valid_i,
    input  wire flush_pkg::fill_req_t  fill_i,

    input  wire logic                  flush_alloc_i,
    input  wire flush_pkg::nline_t     flush_alloc_nline_i,
    input  wire flush_pkg::way_vec_t   flush_alloc_way_i,
    output logic                       flush_alloc_ready_o,

    input  wire flush_pkg::nline_t     flush_check_nline_i,
    output logic                       flush_check_hit_o,

    output logic                       flush_empty_o,
    output logic                       flush_full_o,
    output logic                       flush_busy_o,

    output logic                       flush_ack_o,
    output flush_pkg::nline_t          flush_ack_nline_o,

    output logic                       mem_wreq_valid_o,
    input  wire logic                  mem_wreq_ready_i,
    output flush_pkg::mem_wreq_t       mem_wreq_o,

    output logic                       mem_wdata_valid_o,
    input  wire logic                  mem_wdata_ready_i,
    output flush_pkg::mem_wdata_t      mem_wdata_o,

    input  wire logic                  mem_wresp_valid_i,
    input  wire flush_pkg::mem_wresp_t mem_wresp_i,
    output logic                       mem_wresp_ready_o
);

    import flush_pkg::*;

    logic         rd;
    set_t         rd_set;
    way_vec_t     rd_way;
    acc_idx_t     rd_acc;
    access_data_t rd_data;
    logic         meta_w;
    logic         meta_wok;
    mem_wreq_t    meta;
    logic         rs_w;
    logic         rs_wok;
    acc_word_t    rs_wdata;
    logic         flit_rok;
    mem_data_t    flit;

    flush_data_array data_array_i (
        .clk_i,
        .fill_valid_i,
        .fill_i,
        .rd_i      (rd),
        .rd_set_i  (rd_set),
        .rd_way_i  (rd_way),
        .rd_acc_i  (rd_acc),
        .rd_data_o (rd_data)
    );

    flush_ctrl #(
        .FlushEntries (FlushEntries)
    ) ctrl_i (
        .clk_i,
        .rst_ni,
        .flush_alloc_i,
        .flush_alloc_nline_i,
        .flush_alloc_way_i,
        .flush_alloc_ready_o,
        .flush_empty_o,
        .flush_full_o,
        .flush_busy_o,
        .flush_check_nline_i,
        .flush_check_hit_o,
        .flush_ack_o,
        .flush_ack_nline_o,
        .rd_o       (rd),
        .rd_set_o   (rd_set),
        .rd_way_o   (rd_way),
        .rd_acc_o   (rd_acc),
        .rd_data_i  (rd_data),
        .meta_w_o   (meta_w),
        .meta_wok_i (meta_wok),
        .meta_o     (meta),
        .rs_w_o     (rs_w),
        .rs_wok_i   (rs_wok),
        .rs_wdata_o (rs_wdata),
        .flit_rok_i (flit_rok),
        .flit_i     (flit),
        .mem_wdata_ready_i,
        .mem_wdata_valid_o,
        .mem_wdata_o,
        .mem_wresp_valid_i,
        .mem_wresp_i,
        .mem_wresp_ready_o
    );

    // Request metadata waits here for the memory
    flush_fifo #(
        .Depth     (2),
        .payload_t (mem_wreq_t)
    ) meta_fifo_i (
        .clk_i,
        .rst_ni,
        .w_i     (meta_w),
        .wok_o   (meta_wok),
        .wdata_i (meta),
        .r_i     (mem_wreq_ready_i & mem_wreq_valid_o),
        .rok_o   (mem_wreq_valid_o),
        .rdata_o (mem_wreq_o)
    );

    flush_resize resize_i (
        .clk_i,
        .rst_ni,
        .w_i     (rs_w),
        .wok_o   (rs_wok),
        .wdata_i (rs_wdata),
        .r_i     (mem_wdata_ready_i & mem_wdata_valid_o),
        .rok_o   (flit_rok),
        .rdata_o (flit)
    );

endmodule

`default_nettype wire

// File: tb/tb_flush.sv
`timescale 1ns/1ps
`default_nettype none

module tb_flush;

    import flush_pkg::*;

    localparam int FlushEntries = 4;
    localparam int RandomLines = 40;
    localparam int TotalLines = FlushEntries + RandomLines;
    localparam int TimeoutCycles = 300 * TotalLines;
    localparam logic [31:0] LfsrSeed = 32'haa53b423;

    logic       clk_i = 1'b0;
    logic       rst_ni;
    logic       fill_valid_i;
    fill_req_t  fill_i;
    logic       flush_alloc_i;
    nline_t     flush_alloc_nline_i;
    way_vec_t   flush_alloc_way_i;
    logic       flush_alloc_ready_o;
    nline_t     flush_check_nline_i;
    logic       flush_check_hit_o;
    logic       flush_empty_o;
    logic       flush_full_o;
    logic       flush_busy_o;
    logic       flush_ack_o;
    nline_t     flush_ack_nline_o;
    logic       mem_wreq_valid_o;
    logic       mem_wreq_ready_i;
    mem_wreq_t  mem_wreq_o;
    logic       mem_wdata_valid_o;
    logic       mem_wdata_ready_i;
    mem_wdata_t mem_wdata_o;
    logic       mem_wresp_valid_i;
    mem_wresp_t mem_wresp_i;
    logic       mem_wresp_ready_o;

    // Shadow of the cache contents and of the flush directory
    access_data_t            shadow [1 << SetWidth][Ways][AccessPerLine];
    logic [FlushEntries-1:0] dir_busy = '0;
    nline_t                  dir_nline [FlushEntries];
    mem_wreq_t               exp_req_q [$];
    mem_data_t               exp_flit_q [$];
    mem_id_t                 req_id_q [$];
    int                      flit_idx = 0;
    int                      lines_done = 0;
    int                      ack_cnt = 0;
    nline_t                  last_alloc_nline = '0;
    nline_t                  last_ack_nline = '0;
    logic                    accept_prev = 1'b0;
    logic                    wreq_stall = 1'b0;
    mem_wreq_t               wreq_prev;
    logic                    wdata_stall = 1'b0;
    mem_wdata_t              wdata_prev;
    int                      cycle_cnt = 0;
    logic                    rand_ready;
    logic                    hold_resp;
    logic [31:0]             stim_lfsr;

    flush_subsystem #(
        .FlushEntries (FlushEntries)
    ) flush_subsystem_i (
        .clk_i,
        .rst_ni,
        .fill_valid_i,
        .fill_i,
        .flush_alloc_i,
        .flush_alloc_nline_i,
        .flush_alloc_way_i,
        .flush_alloc_ready_o,
        .flush_check_nline_i,
        .flush_check_hit_o,
        .flush_empty_o,
        .flush_full_o,
        .flush_busy_o,
        .flush_ack_o,
        .flush_ack_nline_o,
        .mem_wreq_valid_o,
        .mem_wreq_ready_i,
        .mem_wreq_o,
        .mem_wdata_valid_o,
        .mem_wdata_ready_i,
        .mem_wdata_o,
        .mem_wresp_valid_i,
        .mem_wresp_i,
        .mem_wresp_ready_o
    );

    always #50 clk_i = ~clk_i;

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] lfsr_bits(inout logic [31:0] state, input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic int way_index(input way_vec_t way);
        int idx;
        idx = 0;
        for (int i = 0; i < Ways; i++) begin
            if (way[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // Even flits carry the low half of a word, odd flits the high half
    function automatic mem_data_t expected_flit(input nline_t nline, input way_vec_t way,
                                                input int index);
        access_data_t word;
        word = shadow[nline[SetWidth-1:0]][way_index(way)][index / 2];
        return (index % 2 == 1) ? word[AccessWidth-1 -: MemDataWidth] : word[MemDataWidth-1:0];
    endfunction

    function automatic int dir_count();
        int cnt;
        cnt = 0;
        for (int i = 0; i < FlushEntries; i++) begin
            cnt += int'(dir_busy[i]);
        end
        return cnt;
    endfunction

    function automatic int lowest_free();
        int idx;
        idx = -1;
        for (int i = FlushEntries - 1; i >= 0; i--) begin
            if (!dir_busy[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_req(input string name, input mem_wreq_t exp, input mem_wreq_t act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flit(input string name, input mem_wdata_t exp, input mem_wdata_t act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_ack(input string name, input nline_t exp, input nline_t act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic fill_line(input set_t set, input way_vec_t way);
        access_data_t word;
        for (int a = 0; a < int'(AccessPerLine); a++) begin
            word = {lfsr_bits(stim_lfsr, 32), lfsr_bits(stim_lfsr, 32)};
            shadow[set][way_index(way)][a] = word;
            fill_valid_i = 1'b1;
            fill_i = '{set: set, way: way, acc: acc_idx_t'(a), data: word};
            @(posedge clk_i);
            #1;
        end
        fill_valid_i = 1'b0;
    endtask

    task automatic flush_line(input nline_t nline, input way_vec_t way);
        flush_alloc_i = 1'b1;
        flush_alloc_nline_i = nline;
        flush_alloc_way_i = way;
        do begin
            @(negedge clk_i);
        end while (!flush_alloc_ready_o);
        @(posedge clk_i);
        #1;
        flush_alloc_i = 1'b0;
        // Next fill waits until both words of this line are read
        while (flush_busy_o) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic flush_random_line();
        logic [31:0] upper;
        set_t        set;
        way_vec_t    way;
        set = set_t'(lfsr_bits(stim_lfsr, SetWidth));
        way = (lfsr_bits(stim_lfsr, 1) != 0) ? way_vec_t'(2) : way_vec_t'(1);
        upper = lfsr_bits(stim_lfsr, NlineWidth - SetWidth);
        fill_line(set, way);
        flush_line({upper[NlineWidth-SetWidth-1:0], set}, way);
    endtask

    // Samples mid-cycle since transfers complete at the next rising edge
    always @(negedge clk_i) begin : monitor
        int         id;
        logic       exp_hit;
        mem_wdata_t exp_flit;
        if (rst_ni) begin
            check_bit("empty", dir_count() == 0, flush_empty_o);
            check_bit("full", dir_count() == FlushEntries, flush_full_o);
            check_bit("wresp ready", 1'b1, mem_wresp_ready_o);
            if (dir_count() == FlushEntries) begin
                check_bit("alloc ready while full", 1'b0, flush_alloc_ready_o);
            end
            if (accept_prev) begin
                check_bit("busy after accept", 1'b1, flush_busy_o);
            end

            // Pending lines hit unless their response arrives now
            exp_hit = 1'b0;
            for (int i = 0; i < FlushEntries; i++) begin
                if (dir_busy[i] && dir_nline[i] == flush_check_nline_i &&
                    !(mem_wresp_valid_i && int'(mem_wresp_i.id) == i)) begin
                    exp_hit = 1'b1;
                end
            end
            check_bit("check hit", exp_hit, flush_check_hit_o);

            accept_prev = flush_alloc_i && flush_alloc_ready_o;
            if (accept_prev) begin
                id = lowest_free();
                if (id < 0) begin
                    fail_run("a line was accepted while the directory was full");
                end
                exp_req_q.push_back('{addr: {flush_alloc_nline_i, {ClOffsetWidth{1'b0}}},
                                      len:  mem_len_t'(FlitsPerLine - 1),
                                      id:   mem_id_t'(id)});
                for (int k = 0; k < int'(FlitsPerLine); k++) begin
                    exp_flit_q.push_back(expected_flit(flush_alloc_nline_i, flush_alloc_way_i, k));
                end
                dir_busy[id] = 1'b1;
                dir_nline[id] = flush_alloc_nline_i;
                last_alloc_nline = flush_alloc_nline_i;
            end

            check_bit("ack valid", mem_wresp_valid_i, flush_ack_o);
            if (mem_wresp_valid_i) begin
                id = int'(mem_wresp_i.id);
                if (id >= FlushEntries || !dir_busy[id]) begin
                    fail_run("write response for a line that is not pending");
                end
                check_ack("ack line", dir_nline[id], flush_ack_nline_o);
                dir_busy[id] = 1'b0;
                last_ack_nline = dir_nline[id];
                ack_cnt++;
            end

            if (wreq_stall) begin
                check_bit("request valid held", 1'b1, mem_wreq_valid_o);
                check_req("request stable", wreq_prev, mem_wreq_o);
            end
            wreq_stall = mem_wreq_valid_o && !mem_wreq_ready_i;
            wreq_prev = mem_wreq_o;
            if (mem_wreq_valid_o && mem_wreq_ready_i) begin
                if (exp_req_q.size() == 0) begin
                    fail_run("write request with no line accepted");
                end
                check_req("request", exp_req_q.pop_front(), mem_wreq_o);
                req_id_q.push_back(mem_wreq_o.id);
            end

            if (wdata_stall) begin
                check_bit("flit valid held", 1'b1, mem_wdata_valid_o);
                check_flit("flit stable", wdata_prev, mem_wdata_o);
            end
            wdata_stall = mem_wdata_valid_o && !mem_wdata_ready_i;
            wdata_prev = mem_wdata_o;
            if (mem_wdata_valid_o && mem_wdata_ready_i) begin
                if (exp_flit_q.size() == 0) begin
                    fail_run("flit sent with no line in flight");
                end
                exp_flit.data = exp_flit_q.pop_front();
                exp_flit.last = (flit_idx == int'(FlitsPerLine) - 1);
                check_flit("flit", exp_flit, mem_wdata_o);
                if (exp_flit.last) begin
                    flit_idx = 0;
                    lines_done++;
                end else begin
                    flit_idx++;
                end
            end
        end
    end

    // Memory side drives ready signals, the check line and delayed write responses
    initial begin : bus_driver
        logic [31:0] bus_lfsr;
        mem_id_t     resp_id_q [$];
        int          resp_due_q [$];
        int          sched;
        int          pick;
        bus_lfsr = LfsrSeed;
        sched = 0;
        mem_wreq_ready_i = 1'b0;
        mem_wdata_ready_i = 1'b0;
        mem_wresp_valid_i = 1'b0;
        mem_wresp_i = '0;
        flush_check_nline_i = '0;
        forever begin
            @(posedge clk_i);
            #1;
            if (rand_ready) begin
                mem_wreq_ready_i = (lfsr_bits(bus_lfsr, 2) != 0);
                mem_wdata_ready_i = (lfsr_bits(bus_lfsr, 2) != 0);
            end else begin
                mem_wreq_ready_i = 1'b1;
                mem_wdata_ready_i = 1'b1;
            end
            flush_check_nline_i = (lfsr_bits(bus_lfsr, 1) != 0) ? last_alloc_nline
                                                                 : last_ack_nline;
            // A line is answered once its request and its last flit are in
            while (sched < lines_done && sched < req_id_q.size()) begin
                resp_id_q.push_back(req_id_q[sched]);
                resp_due_q.push_back(cycle_cnt + int'(lfsr_bits(bus_lfsr, 4)));
                sched++;
            end
            mem_wresp_valid_i = 1'b0;
            pick = -1;
            if (!hold_resp) begin
                for (int k = 0; k < resp_id_q.size(); k++) begin
                    if (pick < 0 && resp_due_q[k] <= cycle_cnt) begin
                        pick = k;
                    end
                end
            end
            if (pick >= 0) begin
                mem_wresp_valid_i = 1'b1;
                mem_wresp_i = '{id: resp_id_q[pick]};
                resp_id_q.delete(pick);
                resp_due_q.delete(pick);
            end
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TimeoutCycles) begin
            fail_run("run timed out before all lines were acknowledged");
        end
    end

    initial begin : main
        stim_lfsr = LfsrSeed;
        rand_ready = 1'b0;
        hold_resp = 1'b0;
        rst_ni = 1'b0;
        fill_valid_i = 1'b0;
        fill_i = '0;
        flush_alloc_i = 1'b0;
        flush_alloc_nline_i = '0;
        flush_alloc_way_i = '0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        @(negedge clk_i);
        check_bit("empty after reset", 1'b1, flush_empty_o);
        check_bit("full after reset", 1'b0, flush_full_o);
        check_bit("busy after reset", 1'b0, flush_busy_o);
        check_bit("alloc ready after reset", 1'b1, flush_alloc_ready_o);
        check_bit("request valid after reset", 1'b0, mem_wreq_valid_o);
        check_bit("flit valid after reset", 1'b0, mem_wdata_valid_o);

        // Fill the directory while the memory holds its responses
        hold_resp = 1'b1;
        @(posedge clk_i);
        #1;
        repeat (FlushEntries) flush_random_line();
        while (lines_done < FlushEntries) @(posedge clk_i);
        @(negedge clk_i);
        check_bit("full with responses held", 1'b1, flush_full_o);
        check_bit("alloc ready with directory full", 1'b0, flush_alloc_ready_o);
        hold_resp = 1'b0;
        @(posedge clk_i);
        #1;
        while (ack_cnt < FlushEntries) @(posedge clk_i);
        @(negedge clk_i);
        check_bit("empty after responses", 1'b1, flush_empty_o);

        // Random back-pressure on both memory channels
        rand_ready = 1'b1;
        @(posedge clk_i);
        #1;
        repeat (RandomLines) flush_random_line();
        while (ack_cnt < TotalLines) @(posedge clk_i);
        @(negedge clk_i);
        check_bit("empty at end", 1'b1, flush_empty_o);
        if (exp_req_q.size() != 0 || exp_flit_q.size() != 0 || lines_done != TotalLines) begin
            fail_run("requests or flits are missing at the end of the run");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
source/flush_pkg.sv
source/flush_fifo.sv
source/flush_resize.sv
source/flush_data_array.sv
source/flush_ctrl.sv
source/flush_subsystem.sv
tb/tb_flush.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the flush testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_flush -o tb_flush \
    && ./obj_dir/tb_flush 2>&1 | tee sim.log \
    || { echo "build or simulation error"; exit 1; }
if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
